// ==== hw/conv_macros.svh ====
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// image geometry, one frame in flight.
`define CONV_IMG_WIDTH 16
`define CONV_IMG_HEIGHT 8

// pixel width.
`define CONV_PIX_W 8
// line ram address, enough for one row.
`define CONV_ADDR_W 4

`endif

// ==== hw/pixel_pkg.sv ====
`include "conv_macros.svh"

package pixel_pkg;

	// one greyscale sample.
	typedef logic [`CONV_PIX_W-1:0] pixel_t;

	// one window column, top row first.
	typedef struct packed
	{
		pixel_t top;
		pixel_t mid;
		pixel_t bot;
	} win_col_t;

	// full 3x3 neighbourhood, centre column holds the output pixel.
	typedef struct packed
	{
		win_col_t left;
		win_col_t centre;
		win_col_t right;
	} window_t;

endpackage

// ==== hw/scan_pkg.sv ====
package scan_pkg;

	// which line ram feeds a window row.
	typedef enum logic [1:0]
	{
		row_idle = 2'd0, // zero row.
		row_c    = 2'd1,
		row_b    = 2'd2,
		row_a    = 2'd3
	} row_src_e;

	typedef struct packed
	{
		row_src_e top;
		row_src_e mid;
		row_src_e bot;
	} row_sel_t;

	// marks first and last window step of an image row.
	typedef struct packed
	{
		logic row_first;
		logic row_last;
	} edge_t;

	typedef enum logic
	{
		mode_smooth = 1'b0,
		mode_edge   = 1'b1
	} filt_mode_e;

endpackage

// ==== hw/line_buffers.sv ====
`timescale 1ns/100ps
`include "conv_macros.svh"

module line_buffers
	import pixel_pkg::*;
(
	input  logic                    clk,
	input  logic [2:0]              wr_sel,
	input  logic [`CONV_ADDR_W-1:0] wr_addr,
	input  logic [`CONV_ADDR_W-1:0] rd_addr,
	input  pixel_t                  wr_pix,
	output pixel_t                  ram_a,
	output pixel_t                  ram_b,
	output pixel_t                  ram_c
);

	pixel_t rd_q [3]; // read words, A B C.
	logic   same_addr;

	assign same_addr = (wr_addr == rd_addr);

	for (genvar k = 0; k < 3; k++)
	begin : g_bank
		pixel_t mem [`CONV_IMG_WIDTH];

		always_ff @(posedge clk)
		begin
			if (wr_sel[k])
			begin
				mem[wr_addr] <= wr_pix;
			end
			// write-first, the bottom row sees the pixel arriving now.
			if (wr_sel[k] && same_addr)
			begin
				rd_q[k] <= wr_pix;
			end
			else
			begin
				rd_q[k] <= mem[rd_addr];
			end
		end
	end

	assign ram_a = rd_q[0];
	assign ram_b = rd_q[1];
	assign ram_c = rd_q[2];

	// the controller writes one row ram at a time.
	assert property (@(posedge clk) !$isunknown(wr_sel) |-> $onehot0(wr_sel))
		else $error("line ram write select not one-hot");

endmodule

// ==== hw/scan_ctrl.sv ====
`timescale 1ns/100ps
`include "conv_macros.svh"

module scan_ctrl
	import scan_pkg::*;
(
	input  logic                    clk,
	input  logic                    aclr,
	input  logic                    in_valid,
	input  filt_mode_e              mode_in,
	output logic [2:0]              wr_sel,
	output logic [`CONV_ADDR_W-1:0] wr_addr,
	output logic [`CONV_ADDR_W-1:0] rd_addr,
	output row_sel_t                row_sel,
	output logic                    shift,
	output edge_t                   edges,
	output logic                    win_valid,
	output filt_mode_e              mode,
	output logic                    busy
);

	localparam int COL_W = $clog2(`CONV_IMG_WIDTH + 1);
	localparam int ROW_W = $clog2(`CONV_IMG_HEIGHT + 1);
	localparam logic [COL_W-1:0] PAD_COL = COL_W'(`CONV_IMG_WIDTH);
	localparam logic [ROW_W-1:0] FLUSH_ROW = ROW_W'(`CONV_IMG_HEIGHT);
	localparam int DRAIN = 4; // shift, window, two kernel stages.

	logic [COL_W-1:0] col; // step within row, PAD_COL is the pad step.
	logic [ROW_W-1:0] row; // FLUSH_ROW is the internal flush row.
	logic [1:0]       wr_idx; // ram being written, 0 1 2 for A B C.
	logic             in_frame;
	logic [2:0]       drain;
	logic             flush;
	logic             pad;
	logic             pix_step;
	logic             step;
	row_src_e         cur_src;
	row_src_e         prev_src;
	row_src_e         old_src;
	row_sel_t         row_sel_d;
	edge_t            edges_d;

	function automatic row_src_e ram_code(input logic [1:0] idx);
		case (idx)
			2'd0:    ram_code = row_a;
			2'd1:    ram_code = row_b;
			default: ram_code = row_c;
		endcase
	endfunction

	function automatic logic [1:0] next_idx(input logic [1:0] idx);
		next_idx = (idx == 2'd2) ? 2'd0 : idx + 2'd1;
	endfunction

	assign flush    = (row == FLUSH_ROW);
	assign pad      = in_frame && (col == PAD_COL);
	assign pix_step = in_valid && !flush;
	assign step     = pix_step || pad || flush;

	assign wr_sel  = pix_step ? (3'b001 << wr_idx) : 3'b000;
	assign wr_addr = col[`CONV_ADDR_W-1:0];
	assign rd_addr = col[`CONV_ADDR_W-1:0]; // same column, all three rams.

	// rotation A B C, so the oldest row sits in the next ram.
	assign cur_src  = ram_code(wr_idx);
	assign prev_src = ram_code(next_idx(next_idx(wr_idx)));
	assign old_src  = ram_code(next_idx(wr_idx));

	always_comb
	begin
		row_sel_d.bot = flush ? row_idle : cur_src;
		row_sel_d.mid = (row == '0) ? row_idle : prev_src;
		row_sel_d.top = (row < ROW_W'(2)) ? row_idle : old_src; // above image row 0.
	end

	assign edges_d.row_first = (col == COL_W'(1));
	assign edges_d.row_last  = (col == PAD_COL);

	always_ff @(posedge clk or posedge aclr)
	begin
		if (aclr)
		begin
			col       <= '0;
			row       <= '0;
			wr_idx    <= 2'd0;
			in_frame  <= 1'b0;
			drain     <= '0;
			mode      <= mode_smooth;
			shift     <= 1'b0;
			row_sel   <= '{top: row_idle, mid: row_idle, bot: row_idle};
			edges     <= '0;
			win_valid <= 1'b0;
		end
		else
		begin
			shift     <= step;
			win_valid <= step && (row != '0) && (col != '0);
			if (step)
			begin
				row_sel <= row_sel_d;
				edges   <= edges_d;
			end
			if (pix_step && !in_frame)
			begin
				in_frame <= 1'b1;
				mode     <= mode_in; // held for the whole frame.
			end
			if (drain != '0)
			begin
				drain <= drain - 3'd1;
			end
			if (step)
			begin
				if (col == PAD_COL)
				begin
					col <= '0;
					if (flush)
					begin
						row      <= '0;
						wr_idx   <= 2'd0;
						in_frame <= 1'b0;
						drain    <= 3'(DRAIN);
					end
					else
					begin
						row    <= row + 1'b1;
						wr_idx <= next_idx(wr_idx);
					end
				end
				else
				begin
					col <= col + 1'b1;
				end
			end
		end
	end

	assign busy = in_frame || (drain != '0);

	// the source holds off while the controller owns the window.
	assert property (@(posedge clk) disable iff (aclr) (pad || flush || drain != '0) |-> !in_valid)
		else $error("input during pad or flush");

	assert property (@(posedge clk) disable iff (aclr) pad |=> !in_valid)
		else $error("input while pad shift pending");

endmodule

// ==== hw/window_mux.sv ====
`timescale 1ns/100ps

module window_mux
	import pixel_pkg::*;
	import scan_pkg::*;
(
	input  logic     clk,
	input  logic     aclr,
	input  pixel_t   ram_a,
	input  pixel_t   ram_b,
	input  pixel_t   ram_c,
	input  row_sel_t row_sel,
	input  logic     shift,
	input  edge_t    edges,
	input  logic     win_valid,
	output window_t  window,
	output logic     win_valid_q
);

	win_col_t new_col;
	win_col_t left_q;
	win_col_t centre_q;
	win_col_t right_q;
	edge_t    edges_q;

	// one row source, idle reads as zero padding.
	function automatic pixel_t pick(input row_src_e src, input pixel_t a, input pixel_t b,
		input pixel_t c);
		case (src)
			row_a:   pick = a;
			row_b:   pick = b;
			row_c:   pick = c;
			default: pick = '0;
		endcase
	endfunction

	assign new_col.top = pick(row_sel.top, ram_a, ram_b, ram_c);
	assign new_col.mid = pick(row_sel.mid, ram_a, ram_b, ram_c);
	assign new_col.bot = pick(row_sel.bot, ram_a, ram_b, ram_c);

	// columns enter on the right.
	always_ff @(posedge clk)
	begin
		if (shift)
		begin
			left_q   <= centre_q;
			centre_q <= right_q;
			right_q  <= new_col;
		end
	end

	always_ff @(posedge clk or posedge aclr)
	begin
		if (aclr)
		begin
			edges_q     <= '0;
			win_valid_q <= 1'b0;
		end
		else
		begin
			win_valid_q <= win_valid;
			if (shift)
			begin
				edges_q <= edges;
			end
		end
	end

	assign window.left   = edges_q.row_first ? '0 : left_q; // previous row's tail.
	assign window.centre = centre_q;
	assign window.right  = edges_q.row_last ? '0 : right_q;

	// a centred pixel always comes with a window move.
	assert property (@(posedge clk) disable iff (aclr) win_valid |-> shift)
		else $error("window valid without shift");

endmodule

// ==== hw/kernel_alu.sv ====
`timescale 1ns/100ps
`include "conv_macros.svh"

module kernel_alu
	import pixel_pkg::*;
	import scan_pkg::*;
(
	input  logic       clk,
	input  logic       aclr,
	input  window_t    window,
	input  logic       win_valid_q,
	input  filt_mode_e mode,
	output logic       out_valid,
	output pixel_t     out_pix
);

	localparam int ACC_W = `CONV_PIX_W + 5; // holds +-8 full-scale pixels.

	typedef logic signed [ACC_W-1:0] acc_t;

	localparam acc_t PIX_MAX = acc_t'((1 << `CONV_PIX_W) - 1);

	acc_t       part_top;
	acc_t       part_mid;
	acc_t       part_bot;
	acc_t       sum;
	filt_mode_e mode_s1;
	logic       valid_s1;

	function automatic acc_t ext(input pixel_t p);
		ext = acc_t'({1'b0, p});
	endfunction

	function automatic acc_t weigh_121(input pixel_t l, input pixel_t c, input pixel_t r);
		weigh_121 = ext(l) + (ext(c) <<< 1) + ext(r);
	endfunction

	function automatic acc_t sum_3(input pixel_t l, input pixel_t c, input pixel_t r);
		sum_3 = ext(l) + ext(c) + ext(r);
	endfunction

	function automatic pixel_t clamp(input acc_t v);
		if (v < 0)
			clamp = '0;
		else if (v > PIX_MAX)
			clamp = '1;
		else
			clamp = v[`CONV_PIX_W-1:0];
	endfunction

	// stage one, row partial sums.
	always_ff @(posedge clk)
	begin
		if (win_valid_q)
		begin
			mode_s1 <= mode;
			if (mode == mode_edge)
			begin
				part_top <= -sum_3(window.left.top, window.centre.top, window.right.top);
				part_mid <= (ext(window.centre.mid) <<< 3) - ext(window.left.mid)
					- ext(window.right.mid);
				part_bot <= -sum_3(window.left.bot, window.centre.bot, window.right.bot);
			end
			else
			begin
				part_top <= weigh_121(window.left.top, window.centre.top, window.right.top);
				part_mid <= weigh_121(window.left.mid, window.centre.mid, window.right.mid) <<< 1;
				part_bot <= weigh_121(window.left.bot, window.centre.bot, window.right.bot);
			end
		end
	end

	assign sum = part_top + part_mid + part_bot;

	// stage two, divide by 16 or clamp.
	always_ff @(posedge clk)
	begin
		if (valid_s1)
		begin
			out_pix <= (mode_s1 == mode_edge) ? clamp(sum) : sum[`CONV_PIX_W+3:4];
		end
	end

	always_ff @(posedge clk or posedge aclr)
	begin
		if (aclr)
		begin
			valid_s1  <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			valid_s1  <= win_valid_q;
			out_valid <= valid_s1;
		end
	end

endmodule

// ==== hw/conv3x3_top.sv ====
`timescale 1ns/100ps
`include "conv_macros.svh"

module conv3x3_top
	import pixel_pkg::*;
	import scan_pkg::*;
(
	input  logic       clk,
	input  logic       aclr,
	input  logic       in_valid,
	input  pixel_t     in_pix,
	input  filt_mode_e mode,
	output logic       out_valid,
	output pixel_t     out_pix,
	output logic       busy
);

	logic [2:0]              wr_sel;
	logic [`CONV_ADDR_W-1:0] wr_addr;
	logic [`CONV_ADDR_W-1:0] rd_addr;
	pixel_t                  ram_a;
	pixel_t                  ram_b;
	pixel_t                  ram_c;
	row_sel_t                row_sel;
	logic                    shift;
	edge_t                   edges;
	logic                    win_valid;
	logic                    win_valid_q;
	window_t                 window;
	filt_mode_e              frame_mode; // mode latched at frame start.

	scan_ctrl i_scan_ctrl (
		.clk       (clk),
		.aclr      (aclr),
		.in_valid  (in_valid),
		.mode_in   (mode),
		.wr_sel    (wr_sel),
		.wr_addr   (wr_addr),
		.rd_addr   (rd_addr),
		.row_sel   (row_sel),
		.shift     (shift),
		.edges     (edges),
		.win_valid (win_valid),
		.mode      (frame_mode),
		.busy      (busy)
	);

	line_buffers i_line_buffers (
		.clk     (clk),
		.wr_sel  (wr_sel),
		.wr_addr (wr_addr),
		.rd_addr (rd_addr),
		.wr_pix  (in_pix),
		.ram_a   (ram_a),
		.ram_b   (ram_b),
		.ram_c   (ram_c)
	);

	window_mux i_window_mux (
		.clk         (clk),
		.aclr        (aclr),
		.ram_a       (ram_a),
		.ram_b       (ram_b),
		.ram_c       (ram_c),
		.row_sel     (row_sel),
		.shift       (shift),
		.edges       (edges),
		.win_valid   (win_valid),
		.window      (window),
		.win_valid_q (win_valid_q)
	);

	kernel_alu i_kernel_alu (
		.clk         (clk),
		.aclr        (aclr),
		.window      (window),
		.win_valid_q (win_valid_q),
		.mode        (frame_mode),
		.out_valid   (out_valid),
		.out_pix     (out_pix)
	);

endmodule

// ==== verification/tb_conv3x3.sv ====
`timescale 1ns/100ps
`include "conv_macros.svh"

module tb_conv3x3
	import pixel_pkg::*;
	import scan_pkg::*;
();

	localparam int W = `CONV_IMG_WIDTH;
	localparam int H = `CONV_IMG_HEIGHT;
	localparam int FRAME_COUNT = 7;
	localparam int FRAME_NS = (W + 3) * (H + 1) * 10;
	localparam int WATCHDOG_NS = FRAME_COUNT * FRAME_NS + 10000; // reset and longer gaps.

	logic       clk;
	logic       aclr;
	logic       in_valid;
	pixel_t     in_pix;
	filt_mode_e mode;
	logic       out_valid;
	pixel_t     out_pix;
	logic       busy;

	pixel_t      img [H][W];
	pixel_t      exp_img [H][W];
	pixel_t      got_q [$]; // output pixels in arrival order.
	logic [31:0] rng_state;

	conv3x3_top i_conv3x3_top (
		.clk       (clk),
		.aclr      (aclr),
		.in_valid  (in_valid),
		.in_pix    (in_pix),
		.mode      (mode),
		.out_valid (out_valid),
		.out_pix   (out_pix),
		.busy      (busy)
	);

	always #5 clk = ~clk;

	always @(negedge clk)
	begin
		if (out_valid === 1'b1)
		begin
			got_q.push_back(out_pix);
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] v;
		v = x;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// zero outside the image.
	function automatic int pix_at(input int r, input int c);
		if (r < 0 || r >= H || c < 0 || c >= W)
			return 0;
		return int'(img[r][c]);
	endfunction

	function automatic pixel_t model_pixel(input filt_mode_e m, input int r, input int c);
		int acc;
		int wt;
		acc = 0;
		for (int dr = -1; dr <= 1; dr++)
		begin
			for (int dc = -1; dc <= 1; dc++)
			begin
				if (m == mode_edge)
					wt = (dr == 0 && dc == 0) ? 8 : -1;
				else
					wt = ((dr == 0) ? 2 : 1) * ((dc == 0) ? 2 : 1);
				acc = acc + wt * pix_at(r + dr, c + dc);
			end
		end
		if (m == mode_smooth)
			return pixel_t'(acc >> 4);
		if (acc < 0)
			return 8'd0;
		if (acc > 255)
			return 8'd255;
		return pixel_t'(acc);
	endfunction

	task automatic build_expected(input filt_mode_e m);
		for (int r = 0; r < H; r++)
		begin
			for (int c = 0; c < W; c++)
			begin
				exp_img[r][c] = model_pixel(m, r, c);
			end
		end
	endtask

	task automatic fail_check(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_pix(input pixel_t got, input pixel_t exp, input int row, input int col);
		if (got !== exp)
			fail_check($sformatf("pixel (%0d,%0d) is %0d, expected %0d", row, col, got, exp));
	endtask

	task automatic check_count(input int got, input int exp);
		if (got != exp)
			fail_check($sformatf("%0d output pixels, expected %0d", got, exp));
	endtask

	task automatic check_busy(input logic exp);
		if (busy !== exp)
			fail_check($sformatf("busy is %b, expected %b", busy, exp));
	endtask

	task automatic check_valid(input logic exp);
		if (out_valid !== exp)
			fail_check($sformatf("out_valid is %b, expected %b", out_valid, exp));
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic reset_dut();
		aclr = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		aclr = 1'b0;
	endtask

	task automatic fill_random();
		for (int r = 0; r < H; r++)
		begin
			for (int c = 0; c < W; c++)
			begin
				rng_state = xorshift32(rng_state);
				img[r][c] = rng_state[15:8];
			end
		end
	endtask

	task automatic fill_const(input pixel_t v);
		for (int r = 0; r < H; r++)
		begin
			for (int c = 0; c < W; c++)
			begin
				img[r][c] = v;
			end
		end
	endtask

	// raster feed, each row followed by at least two idle cycles.
	task automatic feed_frame(input filt_mode_e fmode, input bit vary_gaps, input bit flip_mode);
		int gap;
		got_q.delete();
		mode = fmode;
		for (int r = 0; r < H; r++)
		begin
			for (int c = 0; c < W; c++)
			begin
				in_valid = 1'b1;
				in_pix = img[r][c];
				next_cycle();
				if (r == 0 && c == 0)
				begin
					check_busy(1'b1);
					if (flip_mode)
						mode = (fmode == mode_edge) ? mode_smooth : mode_edge; // must be ignored.
				end
			end
			in_valid = 1'b0;
			in_pix = '0;
			gap = 2;
			if (vary_gaps)
			begin
				rng_state = xorshift32(rng_state);
				gap = 2 + int'(rng_state % 6);
			end
			repeat (gap) next_cycle();
		end
	endtask

	task automatic wait_idle();
		while (busy === 1'b1)
		begin
			next_cycle();
		end
	endtask

	task automatic check_frame();
		check_count(got_q.size(), W * H);
		for (int r = 0; r < H; r++)
		begin
			for (int c = 0; c < W; c++)
			begin
				check_pix(got_q[r * W + c], exp_img[r][c], r, c);
			end
		end
	endtask

	task automatic reset_and_busy();
		check_busy(1'b0);
		check_valid(1'b0);
		fill_random();
		build_expected(mode_smooth);
		feed_frame(mode_smooth, 1'b0, 1'b0);
		while (got_q.size() < W * H)
		begin
			check_busy(1'b1); // high until the last output.
			next_cycle();
		end
		check_busy(1'b0); // busy drops right after the last output.
		check_frame();
		repeat (5) next_cycle();
		check_count(got_q.size(), W * H);
		check_busy(1'b0);
		check_valid(1'b0);
	endtask

	task automatic smooth_constant_image();
		fill_const(8'd16);
		build_expected(mode_smooth);
		feed_frame(mode_smooth, 1'b0, 1'b0);
		wait_idle();
		check_frame();
		check_pix(got_q[0], 8'd9, 0, 0);
		check_pix(got_q[W - 1], 8'd9, 0, W - 1);
		check_pix(got_q[(H - 1) * W], 8'd9, H - 1, 0);
		check_pix(got_q[H * W - 1], 8'd9, H - 1, W - 1);
		check_pix(got_q[5], 8'd12, 0, 5);
		check_pix(got_q[4 * W], 8'd12, 4, 0);
		check_pix(got_q[3 * W + 5], 8'd16, 3, 5);
	endtask

	task automatic edge_random_image();
		fill_random();
		for (int r = 1; r <= 3; r++)
		begin
			for (int c = 6; c <= 8; c++)
			begin
				img[r + 2][c] = 8'd0; // dark ring around a bright dot.
				img[r][c + 3] = 8'd200;
			end
		end
		img[4][7] = 8'd255;
		img[2][10] = 8'd0;
		build_expected(mode_edge);
		feed_frame(mode_edge, 1'b0, 1'b0);
		wait_idle();
		check_frame();
		check_pix(got_q[4 * W + 7], 8'd255, 4, 7);
		check_pix(got_q[2 * W + 10], 8'd0, 2, 10);
	endtask

	task automatic smooth_with_gaps();
		fill_random();
		build_expected(mode_smooth);
		feed_frame(mode_smooth, 1'b0, 1'b0);
		wait_idle();
		check_frame();
		feed_frame(mode_smooth, 1'b1, 1'b0);
		wait_idle();
		check_frame();
	endtask

	task automatic modes_back_to_back();
		fill_const(8'd250);
		build_expected(mode_edge);
		feed_frame(mode_edge, 1'b0, 1'b1);
		wait_idle();
		check_frame();
		// next frame starts the cycle busy falls.
		fill_random();
		build_expected(mode_smooth);
		feed_frame(mode_smooth, 1'b0, 1'b1);
		wait_idle();
		check_frame();
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		abort_run("watchdog expired before all tests finished");
	end

	initial
	begin
		clk = 1'b0;
		aclr = 1'b1;
		in_valid = 1'b0;
		in_pix = '0;
		mode = mode_smooth;
		rng_state = 32'h8c58_1100;
		reset_dut();
		reset_and_busy();
		smooth_constant_image();
		edge_random_image();
		smooth_with_gaps();
		modes_back_to_back();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+hw
hw/pixel_pkg.sv
hw/scan_pkg.sv
hw/line_buffers.sv
hw/scan_ctrl.sv
hw/window_mux.sv
hw/kernel_alu.sv
hw/conv3x3_top.sv
verification/tb_conv3x3.sv
